// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // ------------------------------
    // Widths and constants
    // ------------------------------
    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count = 1 << reg_addr_width;

    localparam logic [xlen-1:0] reset_pc = 32'h3000_0000;

    // RV32I major opcodes in the subset
    localparam logic [6:0] opcode_reg = 7'b0110011;
    localparam logic [6:0] opcode_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal = 7'b1101111;

    // ------------------------------
    // Operations and states
    // ------------------------------
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_lui,
        op_beq,
        op_bne,
        op_jal,
        op_illegal
    } op_t;

    typedef enum logic [2:0] {
        fetch_addr,
        fetch_data,
        fetch_hold,
        fetch_wait_pc,
        fetch_fault
    } fetch_state_t;

    // Decoded instruction handed from decode to execute
    typedef struct packed {
        op_t                       op;
        logic [xlen-1:0]           pc;
        logic [xlen-1:0]           rs1_value;
        logic [xlen-1:0]           rs2_value;
        logic [xlen-1:0]           imm;
        logic [reg_addr_width-1:0] rd;
    } decoded_t;

endpackage

`default_nettype wire

// File: hdl/core_if.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction handoff from fetch to decode
interface fetch_decode_if;
    logic                        valid;
    logic                        ready;
    logic [core_pkg::xlen-1:0]   pc;
    logic [core_pkg::xlen-1:0]   inst;

    modport fetch (
        output valid,
        output pc,
        output inst,
        input  ready
    );

    modport decode (
        input  valid,
        input  pc,
        input  inst,
        output ready
    );
endinterface

// Decoded operation from decode to execute
interface decode_execute_if;
    logic                        valid;
    logic                        ready;
    core_pkg::decoded_t          payload;

    modport master (
        output valid,
        output payload,
        input  ready
    );

    modport slave (
        input  valid,
        input  payload,
        output ready
    );
endinterface

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                        clock,
    input  wire logic                        reset,

    // Redirect from execute
    input  wire logic                        next_pc_valid,
    input  wire logic [core_pkg::xlen-1:0]   next_pc,

    // AXI4 read address channel
    output logic                             arvalid,
    input  wire logic                        arready,
    output logic [core_pkg::xlen-1:0]        araddr,

    // AXI4 read data channel
    input  wire logic                        rvalid,
    input  wire logic [core_pkg::xlen-1:0]   rdata,
    input  wire logic [1:0]                  rresp,
    output logic                             rready,

    output logic                             fetch_fault,

    fetch_decode_if.fetch                    fd
);

    core_pkg::fetch_state_t     state;
    logic [core_pkg::xlen-1:0]  pc;
    logic [core_pkg::xlen-1:0]  inst;

    // ------------------------------
    // Fetch FSM
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= core_pkg::fetch_addr;
            pc <= core_pkg::reset_pc;
        end else begin
            case (state)
                core_pkg::fetch_addr: begin
                    if (arready) begin
                        state <= core_pkg::fetch_data;
                    end
                end
                core_pkg::fetch_data: begin
                    // Any non-OKAY response stops the core for good
                    if (rvalid) begin
                        if (rresp != 2'b00) begin
                            state <= core_pkg::fetch_fault;
                        end else begin
                            state <= core_pkg::fetch_hold;
                        end
                    end
                end
                core_pkg::fetch_hold: begin
                    if (fd.ready) begin
                        state <= core_pkg::fetch_wait_pc;
                    end
                end
                core_pkg::fetch_wait_pc: begin
                    // Pc only moves once execute knows the target
                    if (next_pc_valid) begin
                        pc <= next_pc;
                        state <= core_pkg::fetch_addr;
                    end
                end
                core_pkg::fetch_fault: begin
                    state <= core_pkg::fetch_fault;
                end
                default: begin
                    state <= core_pkg::fetch_fault;
                end
            endcase
        end
    end

    // Instruction word captured on the read beat
    always_ff @(posedge clock) begin
        if (state == core_pkg::fetch_data && rvalid) begin
            inst <= rdata;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign arvalid = (state == core_pkg::fetch_addr);
    assign araddr = pc;
    assign rready = (state == core_pkg::fetch_data);
    assign fetch_fault = (state == core_pkg::fetch_fault);

    // Held stable until decode takes it
    assign fd.valid = (state == core_pkg::fetch_hold);
    assign fd.pc = pc;
    assign fd.inst = inst;

endmodule

`default_nettype wire

// File: hdl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire logic                                  clock,
    input  wire logic                                  reset,

    fetch_decode_if.decode                             fd,
    decode_execute_if.master                           de,

    // Register file write port
    input  wire logic                                  wb_valid,
    input  wire logic [core_pkg::reg_addr_width-1:0]   wb_rd,
    input  wire logic [core_pkg::xlen-1:0]             wb_data
);

    logic [core_pkg::xlen-1:0]            regs [core_pkg::reg_count];

    logic [6:0]                           opcode;
    logic [2:0]                           funct3;
    logic [6:0]                           funct7;
    logic [core_pkg::reg_addr_width-1:0]  rs1;
    logic [core_pkg::reg_addr_width-1:0]  rs2;
    logic [core_pkg::xlen-1:0]            rs1_value;
    logic [core_pkg::xlen-1:0]            rs2_value;
    core_pkg::decoded_t                   decoded;

    assign opcode = fd.inst[6:0];
    assign funct3 = fd.inst[14:12];
    assign funct7 = fd.inst[31:25];
    assign rs1 = fd.inst[19:15];
    assign rs2 = fd.inst[24:20];

    // x0 always reads as zero
    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

    // ------------------------------
    // Field decode and immediates
    // ------------------------------
    always_comb begin
        decoded.op = core_pkg::op_illegal;
        decoded.pc = fd.pc;
        decoded.rs1_value = rs1_value;
        decoded.rs2_value = rs2_value;
        decoded.imm = '0;
        decoded.rd = fd.inst[11:7];
        case (opcode)
            core_pkg::opcode_reg: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    decoded.op = core_pkg::op_add;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    decoded.op = core_pkg::op_sub;
                end else if (funct3 == 3'b111 && funct7 == 7'b0000000) begin
                    decoded.op = core_pkg::op_and;
                end else if (funct3 == 3'b110 && funct7 == 7'b0000000) begin
                    decoded.op = core_pkg::op_or;
                end else if (funct3 == 3'b100 && funct7 == 7'b0000000) begin
                    decoded.op = core_pkg::op_xor;
                end
            end
            core_pkg::opcode_imm: begin
                if (funct3 == 3'b000) begin
                    decoded.op = core_pkg::op_addi;
                end
                decoded.imm = {{20{fd.inst[31]}}, fd.inst[31:20]};
            end
            core_pkg::opcode_lui: begin
                decoded.op = core_pkg::op_lui;
                decoded.imm = {fd.inst[31:12], 12'b0};
            end
            core_pkg::opcode_branch: begin
                if (funct3 == 3'b000) begin
                    decoded.op = core_pkg::op_beq;
                end else if (funct3 == 3'b001) begin
                    decoded.op = core_pkg::op_bne;
                end
                decoded.imm = {{19{fd.inst[31]}}, fd.inst[31], fd.inst[7],
                               fd.inst[30:25], fd.inst[11:8], 1'b0};
            end
            core_pkg::opcode_jal: begin
                decoded.op = core_pkg::op_jal;
                decoded.imm = {{11{fd.inst[31]}}, fd.inst[31], fd.inst[19:12],
                               fd.inst[20], fd.inst[30:21], 1'b0};
            end
            default: begin
                decoded.op = core_pkg::op_illegal;
            end
        endcase
        // Unknown encodings become a no-op
        if (decoded.op == core_pkg::op_illegal) begin
            decoded.rd = '0;
        end
    end

    assign fd.ready = !de.valid || de.ready;

    // ------------------------------
    // Output register and file write
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            de.valid <= 1'b0;
        end else if (fd.valid && fd.ready) begin
            de.valid <= 1'b1;
        end else if (de.ready) begin
            de.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fd.valid && fd.ready) begin
            de.payload <= decoded;
        end
    end

    always_ff @(posedge clock) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire logic                             clock,
    input  wire logic                             reset,

    decode_execute_if.slave                       de,

    // Redirect to fetch
    output logic                                  next_pc_valid,
    output logic [core_pkg::xlen-1:0]             next_pc,

    // Result stage
    output logic                                  wb_valid,
    output logic [core_pkg::xlen-1:0]             wb_pc,
    output logic [core_pkg::reg_addr_width-1:0]   wb_rd,
    output logic [core_pkg::xlen-1:0]             wb_data
);

    core_pkg::decoded_t                   op_in;
    logic [core_pkg::xlen-1:0]            pc_plus4;
    logic [core_pkg::xlen-1:0]            jump_target;
    logic [core_pkg::xlen-1:0]            alu_result;
    logic [core_pkg::xlen-1:0]            target;
    logic [core_pkg::reg_addr_width-1:0]  rd;

    assign op_in = de.payload;
    assign pc_plus4 = op_in.pc + 32'd4;
    assign jump_target = op_in.pc + op_in.imm;

    // ------------------------------
    // ALU and branch resolution
    // ------------------------------
    always_comb begin
        alu_result = '0;
        target = pc_plus4;
        rd = op_in.rd;
        case (op_in.op)
            core_pkg::op_add:  alu_result = op_in.rs1_value + op_in.rs2_value;
            core_pkg::op_sub:  alu_result = op_in.rs1_value - op_in.rs2_value;
            core_pkg::op_and:  alu_result = op_in.rs1_value & op_in.rs2_value;
            core_pkg::op_or:   alu_result = op_in.rs1_value | op_in.rs2_value;
            core_pkg::op_xor:  alu_result = op_in.rs1_value ^ op_in.rs2_value;
            core_pkg::op_addi: alu_result = op_in.rs1_value + op_in.imm;
            core_pkg::op_lui:  alu_result = op_in.imm;
            core_pkg::op_beq: begin
                rd = '0;
                if (op_in.rs1_value == op_in.rs2_value) begin
                    target = jump_target;
                end
            end
            core_pkg::op_bne: begin
                rd = '0;
                if (op_in.rs1_value != op_in.rs2_value) begin
                    target = jump_target;
                end
            end
            core_pkg::op_jal: begin
                // Link value goes to rd
                alu_result = pc_plus4;
                target = jump_target;
            end
            default: begin
                rd = '0;
            end
        endcase
    end

    // Result stage never stalls, so neither does execute
    assign de.ready = 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            next_pc_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            next_pc_valid <= de.valid && de.ready;
            wb_valid <= de.valid && de.ready;
        end
    end

    always_ff @(posedge clock) begin
        if (de.valid && de.ready) begin
            next_pc <= target;
            wb_pc <= op_in.pc;
            wb_rd <= rd;
            wb_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/result_unit.sv
`timescale 1ns/1ps
`default_nettype none

module result_unit (
    input  wire logic                                  clock,
    input  wire logic                                  reset,

    input  wire logic                                  wb_valid,
    input  wire logic [core_pkg::xlen-1:0]             wb_pc,
    input  wire logic [core_pkg::reg_addr_width-1:0]   wb_rd,
    input  wire logic [core_pkg::xlen-1:0]             wb_data,

    // Register file write
    output logic                                       rf_we,
    output logic [core_pkg::reg_addr_width-1:0]        rf_rd,
    output logic [core_pkg::xlen-1:0]                  rf_data,

    // Retire record
    output logic                                       retire_valid,
    output logic [core_pkg::xlen-1:0]                  retire_pc,
    output logic [core_pkg::reg_addr_width-1:0]        retire_rd,
    output logic [core_pkg::xlen-1:0]                  retire_data
);

    always_ff @(posedge clock) begin
        if (reset) begin
            retire_valid <= 1'b0;
            rf_we <= 1'b0;
        end else begin
            retire_valid <= wb_valid;
            rf_we <= wb_valid && (wb_rd != '0);
        end
    end

    always_ff @(posedge clock) begin
        if (wb_valid) begin
            retire_pc <= wb_pc;
            retire_rd <= wb_rd;
            retire_data <= wb_data;
        end
    end

    // Write port shares the retire registers
    assign rf_rd = retire_rd;
    assign rf_data = retire_data;

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire logic                                  clock,
    input  wire logic                                  reset,

    // AXI4 read channels
    output logic                                       arvalid,
    input  wire logic                                  arready,
    output logic [core_pkg::xlen-1:0]                  araddr,
    input  wire logic                                  rvalid,
    output logic                                       rready,
    input  wire logic [core_pkg::xlen-1:0]             rdata,
    input  wire logic [1:0]                            rresp,

    output logic                                       fetch_fault,

    // Retire record
    output logic                                       retire_valid,
    output logic [core_pkg::xlen-1:0]                  retire_pc,
    output logic [core_pkg::reg_addr_width-1:0]        retire_rd,
    output logic [core_pkg::xlen-1:0]                  retire_data
);

    logic                                  next_pc_valid;
    logic [core_pkg::xlen-1:0]             next_pc;
    logic                                  wb_valid;
    logic [core_pkg::xlen-1:0]             wb_pc;
    logic [core_pkg::reg_addr_width-1:0]   wb_rd;
    logic [core_pkg::xlen-1:0]             wb_data;
    logic                                  rf_we;
    logic [core_pkg::reg_addr_width-1:0]   rf_rd;
    logic [core_pkg::xlen-1:0]             rf_data;

    fetch_decode_if   fd_bus ();
    decode_execute_if de_bus ();

    fetch_unit i_fetch (
        .clock         (clock),
        .reset         (reset),
        .next_pc_valid (next_pc_valid),
        .next_pc       (next_pc),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rready        (rready),
        .fetch_fault   (fetch_fault),
        .fd            (fd_bus.fetch)
    );

    decode_unit i_decode (
        .clock    (clock),
        .reset    (reset),
        .fd       (fd_bus.decode),
        .de       (de_bus.master),
        .wb_valid (rf_we),
        .wb_rd    (rf_rd),
        .wb_data  (rf_data)
    );

    execute_unit i_execute (
        .clock         (clock),
        .reset         (reset),
        .de            (de_bus.slave),
        .next_pc_valid (next_pc_valid),
        .next_pc       (next_pc),
        .wb_valid      (wb_valid),
        .wb_pc         (wb_pc),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    result_unit i_result (
        .clock        (clock),
        .reset        (reset),
        .wb_valid     (wb_valid),
        .wb_pc        (wb_pc),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .rf_we        (rf_we),
        .rf_rd        (rf_rd),
        .rf_data      (rf_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

// File: dv/core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module core_assert (
    input wire logic                        clock,
    input wire logic                        reset,
    input wire core_pkg::fetch_state_t      state,
    input wire logic                        arvalid,
    input wire logic                        arready,
    input wire logic [core_pkg::xlen-1:0]   araddr
);

    // Count of failed assertions so far
    int failure_count = 0;

    // Address channel holds until the slave takes it
    hold_address: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
        failure_count = failure_count + 1;
        $error("arvalid or araddr changed before arready");
    end

    legal_state: assert property (@(posedge clock) disable iff (reset)
        state inside {core_pkg::fetch_addr, core_pkg::fetch_data, core_pkg::fetch_hold,
                      core_pkg::fetch_wait_pc, core_pkg::fetch_fault})
    else begin
        failure_count = failure_count + 1;
        $error("fetch state is not a legal encoding");
    end

    no_read_in_fault: assert property (@(posedge clock) disable iff (reset)
        state == core_pkg::fetch_fault |-> !arvalid)
    else begin
        failure_count = failure_count + 1;
        $error("read address issued in fetch_fault");
    end

endmodule

bind fetch_unit core_assert i_core_assert (
    .clock   (clock),
    .reset   (reset),
    .state   (state),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr)
);

`default_nettype wire

// File: dv/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int timeout_cycles = 200;
    localparam int reset_cycles = 16;
    localparam int vector_words = 74;

    logic                                 clock;
    logic                                 reset;
    logic                                 arvalid;
    logic                                 arready;
    logic [core_pkg::xlen-1:0]            araddr;
    logic                                 rvalid;
    logic                                 rready;
    logic [core_pkg::xlen-1:0]            rdata;
    logic [1:0]                           rresp;
    logic                                 fetch_fault;
    logic                                 retire_valid;
    logic [core_pkg::xlen-1:0]            retire_pc;
    logic [core_pkg::reg_addr_width-1:0]  retire_rd;
    logic [core_pkg::xlen-1:0]            retire_data;

    // Vector file image and the program memory built from it
    logic [core_pkg::xlen-1:0]  vectors [vector_words];
    logic [core_pkg::xlen-1:0]  program_mem [logic [core_pkg::xlen-1:0]];
    logic [core_pkg::xlen-1:0]  fault_addr;
    int                         record_count;

    // Memory model state
    integer                     seed;
    logic                       in_reset;
    logic                       data_pending;
    logic [core_pkg::xlen-1:0]  read_addr;
    int                         addr_delay;
    int                         data_delay;

    core_top i_dut (
        .clock        (clock),
        .reset        (reset),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .fetch_fault  (fetch_fault),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #50 clock = ~clock;

    // ------------------------------
    // Checks and waits
    // ------------------------------
    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [core_pkg::xlen-1:0] actual,
                              input logic [core_pkg::xlen-1:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAIL %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_reg(input string name,
                             input logic [core_pkg::reg_addr_width-1:0] actual,
                             input logic [core_pkg::reg_addr_width-1:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAIL %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAIL %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic wait_for_retire();
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clock);
            if (fetch_fault) begin
                stop_with_error("fetch_fault raised before the last expected retire");
            end
            seen = retire_valid;
            cycles++;
            if (!seen && cycles >= timeout_cycles) begin
                stop_with_error("timed out waiting for a retire record");
            end
        end
    endtask

    task automatic wait_for_fault();
        int cycles;
        cycles = 0;
        while (!fetch_fault) begin
            @(negedge clock);
            check_flag("retire_valid", retire_valid, 1'b0);
            cycles++;
            if (!fetch_fault && cycles >= timeout_cycles) begin
                stop_with_error("timed out waiting for fetch_fault");
            end
        end
    endtask

    // The core must stay silent once faulted
    task automatic watch_after_fault();
        repeat (timeout_cycles) begin
            @(negedge clock);
            check_flag("retire_valid", retire_valid, 1'b0);
            check_flag("arvalid", arvalid, 1'b0);
            check_flag("fetch_fault", fetch_fault, 1'b1);
        end
    endtask

    function automatic int draw_delay();
        draw_delay = {$random(seed)} % 4;
    endfunction

    // ------------------------------
    // AXI read memory model
    // ------------------------------
    always @(posedge clock) begin
        in_reset <= reset;
    end

    always @(negedge clock) begin
        if (in_reset) begin
            arready = 1'b0;
            rvalid = 1'b0;
            rdata = '0;
            rresp = '0;
            data_pending = 1'b0;
            addr_delay = draw_delay();
        end else begin
            // rready holds in fetch_data, so a raised beat was taken
            if (rvalid) begin
                rvalid = 1'b0;
                rdata = '0;
                rresp = '0;
                data_pending = 1'b0;
            end
            if (arready) begin
                arready = 1'b0;
                data_pending = 1'b1;
                data_delay = draw_delay();
                addr_delay = draw_delay();
            end else if (arvalid && !data_pending) begin
                if (addr_delay == 0) begin
                    arready = 1'b1;
                    read_addr = araddr;
                end else begin
                    addr_delay = addr_delay - 1;
                end
            end
            if (data_pending && !rvalid) begin
                if (data_delay == 0) begin
                    rvalid = 1'b1;
                    if (read_addr == fault_addr) begin
                        rresp = 2'b10;
                    end else if (program_mem.exists(read_addr)) begin
                        rdata = program_mem[read_addr];
                    end else begin
                        stop_with_error($sformatf("read from %h outside the test program",
                                                  read_addr));
                    end
                end else begin
                    data_delay = data_delay - 1;
                end
            end
            // rready is high exactly while a read beat is owed
            check_flag("rready", rready, data_pending);
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int record;
        int base;
        clock = 1'b0;
        reset = 1'b1;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = '0;
        seed = 32'h57eed8c9;
        $readmemh("dv/core_vectors.txt", vectors);
        record_count = vectors[0];
        fault_addr = vectors[1];
        if (record_count * 4 + 2 != vector_words) begin
            stop_with_error("vector file size does not match its record count");
        end
        for (record = 0; record < record_count; record++) begin
            base = 2 + 4 * record;
            program_mem[vectors[base]] = vectors[base + 1];
        end

        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        check_flag("retire_valid", retire_valid, 1'b0);
        check_flag("fetch_fault", fetch_fault, 1'b0);
        check_flag("arvalid", arvalid, 1'b1);

        // Retire records in program order
        for (record = 0; record < record_count; record++) begin
            base = 2 + 4 * record;
            wait_for_retire();
            check_word("retire_pc", retire_pc, vectors[base]);
            check_reg("retire_rd", retire_rd, vectors[base + 2][core_pkg::reg_addr_width-1:0]);
            check_word("retire_data", retire_data, vectors[base + 3]);
        end

        wait_for_fault();
        check_word("araddr", araddr, fault_addr);
        watch_after_fault();

        if (i_dut.i_fetch.i_core_assert.failure_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            stop_with_error("concurrent assertions failed in the fetch unit");
        end
    end

endmodule

`default_nettype wire

// File: dv/core_vectors.txt
// Header: retire record count, then the address that answers with an error response
// Records in retire order: pc, instruction word, expected rd, expected rd data
00000012 30000060
30000000 00500093 01 00000005 // addi x1, x0, 5
30000004 FFD00113 02 FFFFFFFD // addi x2, x0, -3
30000008 002081B3 03 00000002 // add  x3, x1, x2
3000000C 40208233 04 00000008 // sub  x4, x1, x2
30000010 123452B7 05 12345000 // lui  x5, 0x12345
30000014 67828293 05 12345678 // addi x5, x5, 0x678
30000018 0042F333 06 00000008 // and  x6, x5, x4
3000001C 0032E3B3 07 1234567A // or   x7, x5, x3
30000020 0022C433 08 EDCBA985 // xor  x8, x5, x2
30000024 00708013 00 0000000C // addi x0, x1, 7
30000028 001004B3 09 00000005 // add  x9, x0, x1
3000002C 00208463 00 00000000 // beq  x1, x2, +8 not taken
30000030 00209463 00 00000000 // bne  x1, x2, +8 taken
30000038 00148663 00 00000000 // beq  x9, x1, +12 taken
30000044 00909463 00 00000000 // bne  x1, x9, +8 not taken
30000048 010005EF 0B 3000004C // jal  x11, +16
30000058 00458633 0C 30000054 // add  x12, x11, x4
3000005C 40B606B3 0D 00000008 // sub  x13, x12, x11

// File: sources.f
hdl/core_pkg.sv
hdl/core_if.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/result_unit.sv
hdl/core_top.sv
dv/core_assert.sv
dv/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
